// ==== source/wb_pkg.sv ====
// ----------------------------------------------------------------------
// wishbone bus package
// widths and the master/slave signal bundles of a Wishbone classic port
// ----------------------------------------------------------------------

package wb_pkg;

    localparam int unsigned WB_ADDR_W = 32;
    localparam int unsigned WB_DATA_W = 32;
    localparam int unsigned WB_SEL_W  = WB_DATA_W / 8;

    // master-driven side
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
        logic [WB_SEL_W-1:0]  sel;
    } wb_req_t;

    // slave-driven side with no read data for a write-only master
    typedef struct packed {
        logic ack;
        logic err;
    } wb_rsp_t;

endpackage

// ==== source/sb_pkg.sv ====
// ----------------------------------------------------------------------
// store buffer package
// sizes, access widths, entry states and the port bundles of the
// store buffer, plus the exception codes it reports
// ----------------------------------------------------------------------

package sb_pkg;

    localparam int unsigned SB_DEPTH  = 4;
    localparam int unsigned SB_IDX_W  = $clog2(SB_DEPTH);
    localparam int unsigned ROB_TAG_W = 4;
    localparam int unsigned XLEN      = 32;

    // store access width
    typedef enum logic [1:0] {
        LS_BYTE = 2'd0,
        LS_HALF = 2'd1,
        LS_WORD = 2'd2
    } ls_width_t;

    // exception causes numbered as in the privileged spec
    typedef enum logic [3:0] {
        EXC_NONE            = 4'd0,
        EXC_ST_MISALIGNED   = 4'd6,
        EXC_ST_ACCESS_FAULT = 4'd7
    } exc_code_t;

    // per-entry state
    typedef enum logic [2:0] {
        EMPTY,
        WAIT_OPS,
        READY,
        BUS,
        COMPLETED
    } sb_state_t;

    // register operand whose value is valid once ready is set
    typedef struct packed {
        logic                 ready;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      value;
    } sb_operand_t;

    typedef struct packed {
        ls_width_t            width;
        sb_operand_t          base;
        sb_operand_t          data;
        logic [XLEN-1:0]      imm;
        logic [ROB_TAG_W-1:0] rob_tag;
    } sb_issue_t;

    // result broadcast
    typedef struct packed {
        logic                 valid;
        logic [ROB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      value;
    } sb_cdb_t;

    typedef struct packed {
        logic [ROB_TAG_W-1:0] rob_tag;
        logic                 exc;
        exc_code_t            code;
    } sb_done_t;

    // head store handed to the datapath
    typedef struct packed {
        logic            go;
        ls_width_t       width;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] imm;
    } sb_head_t;

    typedef struct packed {
        logic      done;
        logic      exc;
        exc_code_t code;
    } sb_mem_res_t;

endpackage

// ==== source/sb_entry_queue.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// store buffer entry queue
// ring of store entries with per-entry state, operand capture from the
// broadcast bus, in-order hand-off to the bus and in-order completion
// ----------------------------------------------------------------------

module sb_entry_queue (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                issue_valid_i,
    input  sb_pkg::sb_issue_t   issue_i,
    output logic                issue_ready_o,
    input  sb_pkg::sb_cdb_t     cdb_i,
    output sb_pkg::sb_head_t    head_o,
    input  sb_pkg::sb_mem_res_t mem_res_i,
    output logic                done_valid_o,
    output sb_pkg::sb_done_t    done_o,
    input  logic                done_ready_i
);
    import sb_pkg::*;

    // entry payload
    ls_width_t            ent_width [SB_DEPTH];
    sb_operand_t          ent_base  [SB_DEPTH];
    sb_operand_t          ent_data  [SB_DEPTH];
    logic [XLEN-1:0]      ent_imm   [SB_DEPTH];
    logic [ROB_TAG_W-1:0] ent_tag   [SB_DEPTH];
    logic                 ent_exc   [SB_DEPTH];
    exc_code_t            ent_code  [SB_DEPTH];

    // entry control
    sb_state_t            state_q   [SB_DEPTH];
    sb_state_t            state_d   [SB_DEPTH];
    sb_operand_t          base_cap  [SB_DEPTH];
    sb_operand_t          data_cap  [SB_DEPTH];

    logic [SB_IDX_W-1:0]  head_q;
    logic [SB_IDX_W-1:0]  tail_q;
    logic                 push;
    logic                 pop;
    sb_operand_t          iss_base;
    sb_operand_t          iss_data;

    // take the broadcast value if the operand waits on that tag
    function automatic sb_operand_t capture_op(input sb_operand_t op, input sb_cdb_t cdb);
        sb_operand_t res;
        res = op;
        if (!op.ready && cdb.valid && (cdb.tag == op.tag)) begin
            res.ready = 1'b1;
            res.value = cdb.value;
        end
        return res;
    endfunction

    function automatic logic [SB_IDX_W-1:0] ptr_inc(input logic [SB_IDX_W-1:0] ptr);
        if (ptr == SB_IDX_W'(SB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ------------------------------------------------------------------
    // handshakes
    // ------------------------------------------------------------------

    assign issue_ready_o = (state_q[tail_q] == EMPTY);
    assign push          = issue_valid_i & issue_ready_o;
    assign done_valid_o  = (state_q[head_q] == COMPLETED);
    assign pop           = done_valid_o & done_ready_i;

    // a broadcast in the issue cycle is caught here
    assign iss_base = capture_op(issue_i.base, cdb_i);
    assign iss_data = capture_op(issue_i.data, cdb_i);

    // ------------------------------------------------------------------
    // per-entry state machine
    // ------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            base_cap[i] = capture_op(ent_base[i], cdb_i);
            data_cap[i] = capture_op(ent_data[i], cdb_i);
            state_d[i]  = state_q[i];
            case (state_q[i])
                EMPTY: begin
                    if (push && (tail_q == SB_IDX_W'(i))) begin
                        state_d[i] = (iss_base.ready && iss_data.ready) ? READY : WAIT_OPS;
                    end
                end
                WAIT_OPS: begin
                    if (base_cap[i].ready && data_cap[i].ready) begin
                        state_d[i] = READY;
                    end
                end
                // only the head may go to the bus
                READY: begin
                    if (head_q == SB_IDX_W'(i)) begin
                        state_d[i] = BUS;
                    end
                end
                // at most one entry is ever in BUS
                BUS: begin
                    if (mem_res_i.done) begin
                        state_d[i] = COMPLETED;
                    end
                end
                COMPLETED: begin
                    if (pop && (head_q == SB_IDX_W'(i))) begin
                        state_d[i] = EMPTY;
                    end
                end
                default: state_d[i] = EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SB_DEPTH; i++) begin
                state_q[i] <= EMPTY;
            end
            head_q <= '0;
            tail_q <= '0;
        end else if (flush_i) begin
            for (int i = 0; i < SB_DEPTH; i++) begin
                state_q[i] <= EMPTY;
            end
            head_q <= '0;
            tail_q <= '0;
        end else begin
            for (int i = 0; i < SB_DEPTH; i++) begin
                state_q[i] <= state_d[i];
            end
            if (push) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (pop) begin
                head_q <= ptr_inc(head_q);
            end
        end
    end

    // ------------------------------------------------------------------
    // entry payload update
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (push && (tail_q == SB_IDX_W'(i))) begin
                ent_width[i] <= issue_i.width;
                ent_base[i]  <= iss_base;
                ent_data[i]  <= iss_data;
                ent_imm[i]   <= issue_i.imm;
                ent_tag[i]   <= issue_i.rob_tag;
                ent_exc[i]   <= 1'b0;
                ent_code[i]  <= EXC_NONE;
            end else if (state_q[i] == WAIT_OPS) begin
                ent_base[i] <= base_cap[i];
                ent_data[i] <= data_cap[i];
            end else if ((state_q[i] == BUS) && mem_res_i.done) begin
                // bus outcome for the head store
                ent_exc[i]  <= mem_res_i.exc;
                ent_code[i] <= mem_res_i.code;
            end
        end
    end

    // head store towards datapath and completion port
    assign head_o.go    = (state_q[head_q] == READY);
    assign head_o.width = ent_width[head_q];
    assign head_o.base  = ent_base[head_q].value;
    assign head_o.data  = ent_data[head_q].value;
    assign head_o.imm   = ent_imm[head_q];

    assign done_o.rob_tag = ent_tag[head_q];
    assign done_o.exc     = ent_exc[head_q];
    assign done_o.code    = ent_code[head_q];

endmodule

// ==== source/st_addr_gen.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// store address generator
// base plus offset for the head store, with the alignment check
// ----------------------------------------------------------------------

module st_addr_gen (
    input  sb_pkg::sb_head_t             head_i,
    output logic [wb_pkg::WB_ADDR_W-1:0] addr_o,
    output logic [1:0]                   byte_off_o,
    output logic                         misaligned_o
);
    import sb_pkg::*;

    logic [XLEN-1:0] eff_addr;

    assign eff_addr   = head_i.base + head_i.imm;
    assign addr_o     = eff_addr[wb_pkg::WB_ADDR_W-1:0];
    assign byte_off_o = eff_addr[1:0];

    // half needs an even address, word needs a word boundary
    always_comb begin
        case (head_i.width)
            LS_HALF: misaligned_o = eff_addr[0];
            LS_WORD: misaligned_o = |eff_addr[1:0];
            default: misaligned_o = 1'b0;
        endcase
    end

endmodule

// ==== source/st_lane_align.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// store lane aligner
// moves the store data onto its byte lanes and builds the byte select
// ----------------------------------------------------------------------

module st_lane_align (
    input  sb_pkg::sb_head_t             head_i,
    input  logic [1:0]                   byte_off_i,
    output logic [wb_pkg::WB_DATA_W-1:0] data_o,
    output logic [wb_pkg::WB_SEL_W-1:0]  sel_o
);
    import sb_pkg::*;

    logic [wb_pkg::WB_DATA_W-1:0] lane_src;
    logic [wb_pkg::WB_SEL_W-1:0]  sel_src;
    logic [4:0]                   bit_shift;

    assign bit_shift = {byte_off_i, 3'b000};

    // keep only the bytes the store writes
    always_comb begin
        case (head_i.width)
            LS_BYTE: begin
                lane_src = {24'b0, head_i.data[7:0]};
                sel_src  = 4'b0001;
            end
            LS_HALF: begin
                lane_src = {16'b0, head_i.data[15:0]};
                sel_src  = 4'b0011;
            end
            default: begin
                lane_src = head_i.data[wb_pkg::WB_DATA_W-1:0];
                sel_src  = 4'b1111;
            end
        endcase
    end

    // word stores are aligned, so the shift is zero for them
    assign data_o = lane_src << bit_shift;
    assign sel_o  = sel_src << byte_off_i;

endmodule

// ==== source/sb_wb_master.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// store buffer wishbone master
// one classic single write per head store, reports ack, err or a
// misaligned address back to the queue
// ----------------------------------------------------------------------

module sb_wb_master (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  logic                         go_i,
    input  logic [wb_pkg::WB_ADDR_W-1:0] addr_i,
    input  logic [wb_pkg::WB_DATA_W-1:0] data_i,
    input  logic [wb_pkg::WB_SEL_W-1:0]  sel_i,
    input  logic                         misaligned_i,
    output wb_pkg::wb_req_t              wb_o,
    input  wb_pkg::wb_rsp_t              wb_i,
    output sb_pkg::sb_mem_res_t          mem_res_o
);
    import sb_pkg::*;
    import wb_pkg::*;

    logic                 active_q;
    logic                 res_done_q;
    logic                 res_exc_q;
    exc_code_t            res_code_q;
    logic [WB_ADDR_W-1:0] adr_q;
    logic [WB_DATA_W-1:0] dat_q;
    logic [WB_SEL_W-1:0]  sel_q;

    // ------------------------------------------------------------------
    // idle / active control
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q   <= 1'b0;
            res_done_q <= 1'b0;
            res_exc_q  <= 1'b0;
            res_code_q <= EXC_NONE;
        end else if (flush_i) begin
            // dropping cyc aborts any open cycle
            active_q   <= 1'b0;
            res_done_q <= 1'b0;
        end else begin
            res_done_q <= 1'b0;
            if (!active_q) begin
                if (go_i && misaligned_i) begin
                    res_done_q <= 1'b1;
                    res_exc_q  <= 1'b1;
                    res_code_q <= EXC_ST_MISALIGNED;
                end else if (go_i) begin
                    active_q <= 1'b1;
                end
            end else if (wb_i.ack || wb_i.err) begin
                active_q   <= 1'b0;
                res_done_q <= 1'b1;
                res_exc_q  <= wb_i.err;
                res_code_q <= wb_i.err ? EXC_ST_ACCESS_FAULT : EXC_NONE;
            end
        end
    end

    // request held stable for the whole cycle
    always_ff @(posedge clk_i) begin
        if (!active_q && go_i) begin
            adr_q <= {addr_i[WB_ADDR_W-1:2], 2'b00};
            dat_q <= data_i;
            sel_q <= sel_i;
        end
    end

    assign wb_o.cyc = active_q;
    assign wb_o.stb = active_q;
    assign wb_o.we  = active_q;
    assign wb_o.adr = adr_q;
    assign wb_o.dat = dat_q;
    assign wb_o.sel = sel_q;

    assign mem_res_o.done = res_done_q;
    assign mem_res_o.exc  = res_exc_q;
    assign mem_res_o.code = res_code_q;

endmodule

// ==== source/store_buffer_top.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// store buffer top level
// entry queue, address generation, lane alignment and wishbone master
// ----------------------------------------------------------------------

module store_buffer_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                issue_valid_i,
    input  sb_pkg::sb_issue_t   issue_i,
    output logic                issue_ready_o,
    input  sb_pkg::sb_cdb_t     cdb_i,
    output logic                done_valid_o,
    output sb_pkg::sb_done_t    done_o,
    input  logic                done_ready_i,
    output wb_pkg::wb_req_t     wb_o,
    input  wb_pkg::wb_rsp_t     wb_i
);
    import sb_pkg::*;
    import wb_pkg::*;

    sb_head_t             head;
    sb_mem_res_t          mem_res;
    logic [WB_ADDR_W-1:0] st_addr;
    logic [1:0]           byte_off;
    logic                 misaligned;
    logic [WB_DATA_W-1:0] lane_data;
    logic [WB_SEL_W-1:0]  lane_sel;

    sb_entry_queue i_entry_queue (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .cdb_i         (cdb_i),
        .head_o        (head),
        .mem_res_i     (mem_res),
        .done_valid_o  (done_valid_o),
        .done_o        (done_o),
        .done_ready_i  (done_ready_i)
    );

    st_addr_gen i_addr_gen (
        .head_i       (head),
        .addr_o       (st_addr),
        .byte_off_o   (byte_off),
        .misaligned_o (misaligned)
    );

    st_lane_align i_lane_align (
        .head_i     (head),
        .byte_off_i (byte_off),
        .data_o     (lane_data),
        .sel_o      (lane_sel)
    );

    sb_wb_master i_wb_master (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .go_i         (head.go),
        .addr_i       (st_addr),
        .data_i       (lane_data),
        .sel_i        (lane_sel),
        .misaligned_i (misaligned),
        .wb_o         (wb_o),
        .wb_i         (wb_i),
        .mem_res_o    (mem_res)
    );

endmodule

// ==== tb/tb_checks.svh ====
// ----------------------------------------------------------------------
// store buffer testbench helpers
// random source, reference model of the store rules and the typed
// compare tasks for bus writes, completions and single flags
// ----------------------------------------------------------------------

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// bytes written by one store
function automatic int ref_size(input ls_width_t w);
    case (w)
        LS_BYTE: return 1;
        LS_HALF: return 2;
        default: return 4;
    endcase
endfunction

function automatic logic ref_misaligned(input ls_width_t w, input logic [31:0] addr);
    return (addr % ref_size(w)) != 0;
endfunction

// expected write for an aligned store with its final operand values
function automatic wb_req_t ref_wb(input sb_issue_t st);
    wb_req_t     r;
    logic [31:0] addr;
    int          off;
    int          k;
    addr  = st.base.value + st.imm;
    off   = addr % 4;
    r     = '0;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    r.we  = 1'b1;
    r.adr = addr - off;
    for (k = 0; k < ref_size(st.width); k++) begin
        r.sel[off + k]            = 1'b1;
        r.dat[8 * (off + k) +: 8] = st.data.value[8 * k +: 8];
    end
    return r;
endfunction

function automatic sb_done_t ref_done(input sb_issue_t st);
    sb_done_t    d;
    logic [31:0] addr;
    addr      = st.base.value + st.imm;
    d.rob_tag = st.rob_tag;
    d.exc     = 1'b1;
    if (ref_misaligned(st.width, addr)) begin
        d.code = EXC_ST_MISALIGNED;
    end else if (addr[31:28] == 4'hf) begin
        // error region of the bus model
        d.code = EXC_ST_ACCESS_FAULT;
    end else begin
        d.exc  = 1'b0;
        d.code = EXC_NONE;
    end
    return d;
endfunction

task automatic check_wb(input wb_req_t act, input wb_req_t exp);
    chk_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("mismatch wb_o: adr %h exp %h, dat %h exp %h, sel %h exp %h",
                 act.adr, exp.adr, act.dat, exp.dat, act.sel, exp.sel);
    end
endtask

task automatic check_done(input sb_done_t act, input sb_done_t exp);
    chk_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("mismatch done_o: tag %h exp %h, exc %h exp %h, code %h exp %h",
                 act.rob_tag, exp.rob_tag, act.exc, exp.exc, act.code, exp.code);
    end
endtask

task automatic check_flag(input logic act, input logic exp, input string name);
    chk_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("mismatch %s: got %h expected %h", name, act, exp);
    end
endtask

`endif

// ==== tb/tb_store_buffer.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// store buffer testbench
// issues stores, drives the result broadcast, answers the wishbone
// writes with random wait states and checks writes and completions
// ----------------------------------------------------------------------

module tb_store_buffer;
    import sb_pkg::*;
    import wb_pkg::*;

    localparam int TIMEOUT_CYC = 200;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        issue_valid;
    sb_issue_t   issue;
    logic        issue_ready;
    sb_cdb_t     cdb;
    logic        done_valid;
    sb_done_t    done;
    logic        done_ready;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    int          err_cnt       = 0;
    int          chk_cnt       = 0;
    int          wr_cnt        = 0;
    int          test_err_base = 0;
    logic [31:0] wait_rng      = 32'hf783;
    logic [31:0] data_rng      = 32'hf783;
    logic [3:0]  next_tag      = 4'd1;
    wb_req_t     exp_wb_q[$];
    sb_done_t    exp_done_q[$];

    `include "tb_checks.svh"

    store_buffer_top i_store_buffer_top (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .flush_i       (flush),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .issue_ready_o (issue_ready),
        .cdb_i         (cdb),
        .done_valid_o  (done_valid),
        .done_o        (done),
        .done_ready_i  (done_ready),
        .wb_o          (wb_req),
        .wb_i          (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ------------------------------------------------------------------
    // wishbone slave model and completion monitor
    // ------------------------------------------------------------------

    initial begin : wb_responder
        logic busy;
        int   wait_left;
        wb_rsp    = '0;
        busy      = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #10;
            if (wb_rsp.ack || wb_rsp.err) begin
                wb_rsp = '0;
                busy   = 1'b0;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wr_cnt++;
                    wait_rng  = xorshift(wait_rng);
                    wait_left = wait_rng % 3;
                    if (exp_wb_q.size() == 0) begin
                        err_cnt++;
                        $display("bus write to %h that no store should make", wb_req.adr);
                    end else begin
                        check_wb(wb_req, exp_wb_q.pop_front());
                    end
                end else if (wait_left > 0) begin
                    wait_left--;
                end
                if (wait_left == 0) begin
                    wb_rsp.ack = (wb_req.adr[31:28] != 4'hf);
                    wb_rsp.err = (wb_req.adr[31:28] == 4'hf);
                end
            end else begin
                // cycle aborted by a flush
                busy = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && done_valid && done_ready) begin
            if (exp_done_q.size() == 0) begin
                err_cnt++;
                $display("completion for tag %h with no store outstanding", done.rob_tag);
            end else begin
                check_done(done, exp_done_q.pop_front());
            end
        end
    end

    // ------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    function automatic sb_issue_t make_store(input ls_width_t w, input logic [31:0] base,
            input logic [31:0] data, input logic [31:0] imm);
        sb_issue_t st;
        st            = '0;
        st.width      = w;
        st.base.ready = 1'b1;
        st.base.value = base;
        st.data.ready = 1'b1;
        st.data.value = data;
        st.imm        = imm;
        return st;
    endfunction

    // expectations use the operand values the store ends up with
    task automatic issue_store(input sb_issue_t st, input logic [31:0] base_fin,
            input logic [31:0] data_fin);
        sb_issue_t full;
        int        n;
        st.rob_tag      = next_tag;
        next_tag        = next_tag + 1'b1;
        full            = st;
        full.base.value = base_fin;
        full.data.value = data_fin;
        if (!ref_misaligned(st.width, base_fin + st.imm)) begin
            exp_wb_q.push_back(ref_wb(full));
        end
        exp_done_q.push_back(ref_done(full));
        issue       = st;
        issue_valid = 1'b1;
        n           = 0;
        @(negedge clk);
        while (!issue_ready && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        if (!issue_ready) begin
            err_cnt++;
            $display("store with tag %h was never accepted", st.rob_tag);
        end
        step(1);
        issue_valid = 1'b0;
    endtask

    task automatic send_cdb(input logic [3:0] tag, input logic [31:0] value);
        cdb.valid = 1'b1;
        cdb.tag   = tag;
        cdb.value = value;
        step(1);
        cdb = '0;
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (exp_done_q.size() != 0 && n < TIMEOUT_CYC) begin
            step(1);
            n++;
        end
        if (exp_done_q.size() != 0) begin
            err_cnt++;
            $display("timed out, %0d completions missing in %s", exp_done_q.size(), what);
        end
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err_base) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: fail with %0d errors", name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    // ------------------------------------------------------------------
    // test sequences
    // ------------------------------------------------------------------

    initial begin : stimulus
        sb_issue_t st;
        int        wr_base;
        int        k;
        int        n;
        rst_n       = 1'b0;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        cdb         = '0;
        done_ready  = 1'b1;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        step(2);

        wr_base = wr_cnt;
        for (k = 0; k < 3; k++) begin
            data_rng = xorshift(data_rng);
            st = make_store(LS_WORD, 32'h1000_0000, data_rng, 32'(4 * k));
            issue_store(st, st.base.value, st.data.value);
        end
        wait_drain("word stores");
        check_flag(wr_cnt == wr_base + 3, 1'b1, "write count of word stores");
        end_test("test 1 aligned word stores");

        wr_base = wr_cnt;
        for (k = 0; k < 4; k++) begin
            data_rng = xorshift(data_rng);
            st = make_store(LS_BYTE, 32'h2000_0100, data_rng, 32'(k));
            issue_store(st, st.base.value, st.data.value);
        end
        for (k = 0; k < 4; k += 2) begin
            data_rng = xorshift(data_rng);
            st = make_store(LS_HALF, 32'h2000_0100, data_rng, 32'(k));
            issue_store(st, st.base.value, st.data.value);
        end
        wait_drain("byte and half stores");
        check_flag(wr_cnt == wr_base + 6, 1'b1, "write count of byte and half stores");
        end_test("test 2 byte and half lanes");

        // both operands arrive later in two broadcasts
        wr_base = wr_cnt;
        st = make_store(LS_WORD, 32'h0, 32'h0, 32'h8);
        st.base.ready = 1'b0;
        st.base.tag   = 4'd10;
        st.data.ready = 1'b0;
        st.data.tag   = 4'd11;
        issue_store(st, 32'h3000_0020, 32'hcafe_f00d);
        step(4);
        check_flag(wr_cnt == wr_base, 1'b1, "write with both operands pending");
        send_cdb(4'd10, 32'h3000_0020);
        step(3);
        check_flag(wr_cnt == wr_base, 1'b1, "write with data operand pending");
        send_cdb(4'd11, 32'hcafe_f00d);
        wait_drain("pending operands");
        st = make_store(LS_HALF, 32'h3000_0040, 32'h0, 32'h2);
        st.data.ready = 1'b0;
        st.data.tag   = 4'd12;
        cdb.valid = 1'b1;
        cdb.tag   = 4'd12;
        cdb.value = 32'h0000_beef;
        issue_store(st, 32'h3000_0040, 32'h0000_beef);
        cdb = '0;
        wait_drain("broadcast in issue cycle");
        check_flag(wr_cnt == wr_base + 2, 1'b1, "write count of pending stores");
        end_test("test 3 pending operands");

        wr_base = wr_cnt;
        st = make_store(LS_HALF, 32'h4000_0000, 32'h1234, 32'h1);
        issue_store(st, st.base.value, st.data.value);
        st = make_store(LS_HALF, 32'h4000_0000, 32'h5678, 32'h3);
        issue_store(st, st.base.value, st.data.value);
        st = make_store(LS_WORD, 32'h4000_0000, 32'h5678_9abc, 32'h2);
        issue_store(st, st.base.value, st.data.value);
        st = make_store(LS_WORD, 32'h4000_0001, 32'h1111_2222, 32'h0);
        issue_store(st, st.base.value, st.data.value);
        wait_drain("misaligned stores");
        check_flag(wr_cnt == wr_base, 1'b1, "bus cycle for misaligned store");
        end_test("test 4 misaligned stores");

        wr_base = wr_cnt;
        st = make_store(LS_WORD, 32'hf000_0000, 32'hdead_beef, 32'h10);
        issue_store(st, st.base.value, st.data.value);
        st = make_store(LS_WORD, 32'h1000_0000, 32'h0bad_cafe, 32'h40);
        issue_store(st, st.base.value, st.data.value);
        wait_drain("bus error");
        check_flag(wr_cnt == wr_base + 2, 1'b1, "write count around bus error");
        end_test("test 5 bus error");

        // head held completed while the rest queue up behind it
        wr_base    = wr_cnt;
        done_ready = 1'b0;
        for (k = 0; k < SB_DEPTH; k++) begin
            data_rng = xorshift(data_rng);
            st = make_store(LS_WORD, 32'h5000_0000, data_rng, 32'(4 * k));
            issue_store(st, st.base.value, st.data.value);
        end
        check_flag(issue_ready, 1'b0, "issue_ready_o with buffer full");
        n = 0;
        while (!done_valid && n < TIMEOUT_CYC) begin
            step(1);
            n++;
        end
        check_flag(done_valid, 1'b1, "done_valid_o of held head");
        step(6);
        check_flag(wr_cnt == wr_base + 1, 1'b1, "single write while head waits");
        flush = 1'b1;
        step(1);
        flush = 1'b0;
        exp_wb_q.delete();
        exp_done_q.delete();
        check_flag(issue_ready, 1'b1, "issue_ready_o after flush");
        check_flag(done_valid, 1'b0, "done_valid_o after flush");
        done_ready = 1'b1;
        st = make_store(LS_WORD, 32'h6000_0000, 32'h7777_8888, 32'h4);
        issue_store(st, st.base.value, st.data.value);
        wait_drain("store after flush");
        check_flag(wr_cnt == wr_base + 2, 1'b1, "write count after flush");
        end_test("test 6 back-pressure and flush");

        $display("checks run %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+tb
source/wb_pkg.sv
source/sb_pkg.sv
source/sb_entry_queue.sv
source/st_addr_gen.sv
source/st_lane_align.sv
source/sb_wb_master.sv
source/store_buffer_top.sv
tb/tb_store_buffer.sv

// ==== Bender.yml ====
package:
  name: store_buffer

sources:
  - source/wb_pkg.sv
  - source/sb_pkg.sv
  - source/sb_entry_queue.sv
  - source/st_addr_gen.sv
  - source/st_lane_align.sv
  - source/sb_wb_master.sv
  - source/store_buffer_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_store_buffer.sv
